// ==== hdl/mac_array_pkg.sv ====
/*
 * Shared sizes, Wishbone address map, bus and control structs, FSM states.
 * Every RTL file imports this package in its module header.
 */
package mac_array_pkg;

  // Array geometry
  localparam int unsigned ROWS       = 4;                       // Engine rows
  localparam int unsigned PE_PER_ROW = 4;                       // Multiply-add stages per row
  localparam int unsigned K_DIM      = 8;                       // Inner dimension
  localparam int unsigned N_COLS     = 4;                       // Output columns
  localparam int unsigned NUM_PASS   = K_DIM / PE_PER_ROW;      // Passes per output element
  localparam int unsigned DATA_W     = 8;                       // Operand width
  localparam int unsigned ACC_W      = 32;                      // Accumulator width
  localparam int unsigned PIPE_DEPTH = 2;                       // Row latency in cycles
  localparam int unsigned COL_W      = $clog2(N_COLS);          // Column index width
  localparam int unsigned PASS_W     = $clog2(NUM_PASS);        // Pass index width

  // Wishbone geometry
  localparam int unsigned WB_AW = 10;
  localparam int unsigned WB_DW = 32;

  // Byte address map
  localparam logic [WB_AW-1:0] ADDR_CTRL   = 10'h000;           // Bit 0 starts a run
  localparam logic [WB_AW-1:0] ADDR_STATUS = 10'h004;           // Bit 0 busy, bit 1 done
  localparam logic [WB_AW-1:0] ADDR_X_BASE = 10'h040;           // 8 words, r*2+q
  localparam logic [WB_AW-1:0] ADDR_W_BASE = 10'h080;           // 8 words, one per k
  localparam logic [WB_AW-1:0] ADDR_B_BASE = 10'h0C0;           // 4 words, one per row
  localparam logic [WB_AW-1:0] ADDR_Z_BASE = 10'h100;           // 16 words, r*4+n, read only

  // Operand types
  typedef logic signed [DATA_W-1:0] operand_t;
  typedef operand_t [PE_PER_ROW-1:0] operand_vec_t;             // Lowest byte is element 0
  typedef operand_vec_t [ROWS-1:0] x_rows_t;                    // One X slice per row
  typedef operand_vec_t [ROWS-1:0][NUM_PASS-1:0] x_mat_t;       // x[r][4q+i] at [r][q][i]
  typedef operand_vec_t [K_DIM-1:0] w_mat_t;                    // w[k][n] at [k][n]
  typedef logic [ROWS-1:0][ACC_W-1:0] acc_vec_t;

  // Wishbone classic
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
    logic [3:0]       sel;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  // Sequencer to engine
  typedef struct packed {
    logic         in_valid;
    logic         accumulate;                                   // Feed back last row result
    operand_vec_t w_slice;                                      // Shared by all rows
  } engine_ctrl_t;

  typedef struct packed {
    logic [ROWS-1:0] out_valid;
    logic            busy;
  } engine_flags_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    DONE
  } seq_state_e;

endpackage

// ==== hdl/mac_ctrl.sv ====
/*
 * Run sequencer. Walks the output columns and the passes per column,
 * one beat in flight at a time, and writes each finished column to Z.
 * A run of 16 results takes 25 cycles from the start pulse.
 */
module mac_ctrl
  import mac_array_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             start_i,        // One cycle pulse from the register file
  input  x_mat_t           x_full_i,
  input  w_mat_t           w_full_i,
  output engine_ctrl_t     ctrl_o,
  output x_rows_t          x_slice_o,      // X slice of the current pass
  input  engine_flags_t    flags_i,
  input  acc_vec_t         result_i,
  output logic             z_we_o,
  output logic [COL_W-1:0] z_col_o,
  output acc_vec_t         z_row_vec_o,
  output logic             busy_o,
  output logic             done_o
);

  seq_state_e        state_q;
  logic [COL_W-1:0]  col_q;                // Output column n
  logic [PASS_W-1:0] pass_q;               // Pass p over k
  logic              done_q;
  logic              beat_done;
  logic              last_pass;

  assign beat_done = &flags_i.out_valid;
  assign last_pass = (pass_q == PASS_W'(NUM_PASS-1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      col_q   <= '0;
      pass_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= ISSUE;
            col_q   <= '0;
            pass_q  <= '0;
            done_q  <= 1'b0;             // Done stays until the next start
          end
        end
        ISSUE: state_q <= WAIT;          // One beat per ISSUE
        WAIT: begin
          if (beat_done) begin
            if (!last_pass) begin
              pass_q  <= pass_q + 1'b1;
              state_q <= ISSUE;
            end else begin
              pass_q <= '0;
              if (col_q == COL_W'(N_COLS-1)) begin
                state_q <= DONE;
              end else begin
                col_q   <= col_q + 1'b1;
                state_q <= ISSUE;
              end
            end
          end
        end
        DONE: begin
          if (!flags_i.busy) begin       // Rows drained
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Beat operands, weights w[4p+i][n] and X slice p
  always_comb begin : beat_operands
    ctrl_o.in_valid   = (state_q == ISSUE);
    ctrl_o.accumulate = (pass_q != '0);  // Held through WAIT, used at stage two
    for (int i = 0; i < PE_PER_ROW; i++) begin
      ctrl_o.w_slice[i] = w_full_i[PE_PER_ROW*pass_q + i][col_q];
    end
    for (int r = 0; r < ROWS; r++) begin
      x_slice_o[r] = x_full_i[r][pass_q];
    end
  end

  assign z_we_o      = (state_q == WAIT) && beat_done && last_pass;
  assign z_col_o     = col_q;
  assign z_row_vec_o = result_i;
  assign busy_o      = (state_q != IDLE);
  assign done_o      = done_q;

  // Feedback holds one result per row, so a beat only enters empty rows
  a_no_issue_in_wait: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ctrl_o.in_valid |-> !flags_i.busy
  ) else $error("new beat issued while a beat is still in the rows");

  // A second start must not restart the column and pass walk
  a_start_ignored_busy: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (start_i && busy_o) |=> !(state_q == ISSUE && col_q == '0 && pass_q == '0)
  ) else $error("start while busy disturbed the running sequence");

endmodule

// ==== hdl/mac_engine.sv ====
/*
 * Array of ROWS rows. Each row takes either the external bias or its own
 * last result, which lets a long dot product run as several passes.
 */
module mac_engine
  import mac_array_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  x_rows_t       x_mat_i,        // One X slice per row
  input  acc_vec_t      bias_i,
  input  engine_ctrl_t  ctrl_i,
  output acc_vec_t      result_o,
  output engine_flags_t flags_o
);

  acc_vec_t result, feedback;
  logic [$clog2(PIPE_DEPTH+1)-1:0] inflight_q;   // Items inside the rows

  for (genvar r = 0; r < ROWS; r++) begin : gen_rows

    mac_row u_row (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .x_i      (x_mat_i[r]),
      .w_i      (ctrl_i.w_slice),            // Weights broadcast to all rows
      .bias_i   (feedback[r]),
      .valid_i  (ctrl_i.in_valid),
      .result_o (result[r]),
      .valid_o  (flags_o.out_valid[r])
    );

    // Second pass adds onto the first one
    always_comb begin : bias_mux
      if (ctrl_i.accumulate) begin
        feedback[r] = result[r];
      end else begin
        feedback[r] = bias_i[r];
      end
    end

  end

  // Rows run in lockstep, row 0 stands for all of them
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inflight_q <= '0;
    end else if (ctrl_i.in_valid && !flags_o.out_valid[0]) begin
      inflight_q <= inflight_q + 1'b1;
    end else if (!ctrl_i.in_valid && flags_o.out_valid[0]) begin
      inflight_q <= inflight_q - 1'b1;
    end
  end

  assign flags_o.busy = (inflight_q != '0);
  assign result_o     = result;

endmodule

// ==== hdl/mac_row.sv ====
/*
 * One engine row: four multiply-add stages over a shared bias input.
 * Stage one registers the products, stage two registers their sum plus bias.
 */
module mac_row
  import mac_array_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  operand_vec_t     x_i,          // X slice for this row
  input  operand_vec_t     w_i,          // Weight slice, same for every row
  input  logic [ACC_W-1:0] bias_i,       // Bias or fed back partial sum
  input  logic             valid_i,
  output logic [ACC_W-1:0] result_o,
  output logic             valid_o
);

  logic [PE_PER_ROW-1:0][ACC_W-1:0] prod_d, prod_q;
  logic [ACC_W-1:0]                 sum_d, result_q;
  logic [PIPE_DEPTH-1:0]            valid_q;

  // Sign-extended products, multiply happens at accumulator width
  always_comb begin : products
    logic signed [ACC_W-1:0] prod_ext;
    prod_ext = '0;
    for (int i = 0; i < PE_PER_ROW; i++) begin
      prod_ext  = $signed(x_i[i]) * $signed(w_i[i]);
      prod_d[i] = prod_ext;
    end
  end

  // Adder chain starting from the bias, wraps at ACC_W bits
  always_comb begin : add_chain
    sum_d = bias_i;
    for (int i = 0; i < PE_PER_ROW; i++) begin
      sum_d = sum_d + prod_q[i];
    end
  end

  // Payload stages load only with a valid item so result_q holds for feedback
  always_ff @(posedge clk_i) begin
    if (valid_i) prod_q <= prod_d;
    if (valid_q[0]) result_q <= sum_d;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[PIPE_DEPTH-2:0], valid_i};  // Valid follows the data
    end
  end

  assign result_o = result_q;
  assign valid_o  = valid_q[PIPE_DEPTH-1];

  // Fixed latency, no stalls inside the row
  a_fixed_latency: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    valid_o == $past(valid_i, PIPE_DEPTH)
  ) else $error("row valid_o does not match valid_i delayed by PIPE_DEPTH");

endmodule

// ==== hdl/mac_top.sv ====
/*
 * Matrix-multiply engine top, Z = X*W + bias over a Wishbone classic slave.
 * Write operands, write CTRL bit 0, then poll STATUS until done.
 */
module mac_top
  import mac_array_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  logic             start, busy, done;
  logic             z_we;
  logic [COL_W-1:0] z_col;
  acc_vec_t         z_row_vec, bias, eng_result;
  x_mat_t           x_mat;
  w_mat_t           w_mat;
  x_rows_t          x_slice;
  engine_ctrl_t     eng_ctrl;
  engine_flags_t    eng_flags;

  mac_wb_regs u_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .wb_req_i    (wb_req_i),
    .wb_rsp_o    (wb_rsp_o),
    .busy_i      (busy),
    .done_i      (done),
    .z_we_i      (z_we),
    .z_col_i     (z_col),
    .z_row_vec_i (z_row_vec),
    .start_o     (start),
    .x_mat_o     (x_mat),
    .w_mat_o     (w_mat),
    .bias_o      (bias)
  );

  mac_ctrl u_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .start_i     (start),
    .x_full_i    (x_mat),
    .w_full_i    (w_mat),
    .ctrl_o      (eng_ctrl),
    .x_slice_o   (x_slice),
    .flags_i     (eng_flags),
    .result_i    (eng_result),
    .z_we_o      (z_we),
    .z_col_o     (z_col),
    .z_row_vec_o (z_row_vec),
    .busy_o      (busy),
    .done_o      (done)
  );

  mac_engine u_engine (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .x_mat_i  (x_slice),
    .bias_i   (bias),
    .ctrl_i   (eng_ctrl),
    .result_o (eng_result),
    .flags_o  (eng_flags)
  );

endmodule

// ==== hdl/mac_wb_regs.sv ====
/*
 * Wishbone classic slave. Holds X, W, bias and Z, the control word and
 * the status word. Ack is registered, so every access takes two cycles.
 */
module mac_wb_regs
  import mac_array_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  wb_req_t          wb_req_i,
  output wb_rsp_t          wb_rsp_o,
  input  logic             busy_i,
  input  logic             done_i,
  input  logic             z_we_i,         // Column write from the sequencer
  input  logic [COL_W-1:0] z_col_i,
  input  acc_vec_t         z_row_vec_i,
  output logic             start_o,
  output x_mat_t           x_mat_o,
  output w_mat_t           w_mat_o,
  output acc_vec_t         bias_o
);

  x_mat_t                  x_q;
  w_mat_t                  w_q;
  acc_vec_t                bias_q;
  acc_vec_t [N_COLS-1:0]   z_q;            // z[r][n] at z_q[n][r]
  logic                    ack_q;
  logic                    start_q;
  logic [WB_DW-1:0]        rdat_d, rdat_q;
  logic                    req_fire, wr_fire, op_wr;
  logic                    hit_ctrl, hit_status, hit_x, hit_w, hit_b, hit_z;
  logic [WB_AW-1:0]        adr;

  // Byte lane merge for partial writes
  function automatic logic [WB_DW-1:0] merge_bytes(input logic [WB_DW-1:0] old_w,
                                                   input logic [WB_DW-1:0] new_w,
                                                   input logic [3:0]       sel);
    logic [WB_DW-1:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  assign adr      = wb_req_i.adr;
  assign req_fire = wb_req_i.cyc && wb_req_i.stb && !ack_q;  // No access in the ack cycle
  assign wr_fire  = req_fire && wb_req_i.we;
  assign op_wr    = wr_fire && !busy_i;    // Operands frozen during a run

  // Address decode, low two bits ignored
  assign hit_ctrl   = (adr[WB_AW-1:2] == ADDR_CTRL[WB_AW-1:2]);
  assign hit_status = (adr[WB_AW-1:2] == ADDR_STATUS[WB_AW-1:2]);
  assign hit_x      = (adr[WB_AW-1:5] == ADDR_X_BASE[WB_AW-1:5]);
  assign hit_w      = (adr[WB_AW-1:5] == ADDR_W_BASE[WB_AW-1:5]);
  assign hit_b      = (adr[WB_AW-1:4] == ADDR_B_BASE[WB_AW-1:4]);
  assign hit_z      = (adr[WB_AW-1:6] == ADDR_Z_BASE[WB_AW-1:6]);

  always_comb begin : read_mux
    rdat_d = '0;                           // Unmapped reads return 0
    if (hit_status) rdat_d = {{(WB_DW-2){1'b0}}, done_i, busy_i};
    if (hit_x)      rdat_d = x_q[adr[4:3]][adr[2]];
    if (hit_w)      rdat_d = w_q[adr[4:2]];
    if (hit_b)      rdat_d = bias_q[adr[3:2]];
    if (hit_z)      rdat_d = z_q[adr[3:2]][adr[5:4]];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      ack_q   <= req_fire;
      start_q <= wr_fire && hit_ctrl && wb_req_i.sel[0] && wb_req_i.dat[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) rdat_q <= rdat_d;
  end

  // Operand storage, writes while busy are acked and dropped
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_q    <= '0;
      w_q    <= '0;
      bias_q <= '0;
    end else if (op_wr) begin
      if (hit_x) x_q[adr[4:3]][adr[2]] <= merge_bytes(x_q[adr[4:3]][adr[2]],
                                                      wb_req_i.dat, wb_req_i.sel);
      if (hit_w) w_q[adr[4:2]] <= merge_bytes(w_q[adr[4:2]], wb_req_i.dat, wb_req_i.sel);
      if (hit_b) bias_q[adr[3:2]] <= merge_bytes(bias_q[adr[3:2]], wb_req_i.dat,
                                                 wb_req_i.sel);
    end
  end

  // Results, only the sequencer writes here
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      z_q <= '0;
    end else if (z_we_i) begin
      z_q[z_col_i] <= z_row_vec_i;          // Whole column, all rows at once
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;
  assign start_o      = start_q;
  assign x_mat_o      = x_q;
  assign w_mat_o      = w_q;
  assign bias_o       = bias_q;

  // Ack lands while the master still holds the request it answers
  a_ack_follows_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb && $past(wb_req_i.cyc && wb_req_i.stb))
  ) else $error("ack raised without a held cyc and stb");

endmodule

// ==== mac_array.f ====
hdl/mac_array_pkg.sv
hdl/mac_row.sv
hdl/mac_engine.sv
hdl/mac_ctrl.sv
hdl/mac_wb_regs.sv
hdl/mac_top.sv
testbench/mac_checker.sv
testbench/mac_tb.sv

// ==== testbench/mac_checker.sv ====
/*
 * Wishbone snooper at the DUT ports. Keeps shadow X, W and bias, predicts Z
 * at every start and compares the data of every acked read.
 */
module mac_checker
  import mac_array_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  wb_req_t wb_req_i,
  input  wb_rsp_t wb_rsp_i,
  output int      err_cnt_o,
  output int      chk_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] x_sh [8];          // Word r*2+q, bytes x[r][4q..4q+3]
  logic [31:0] w_sh [8];          // Word k, bytes w[k][0..3]
  logic [31:0] b_sh [4];
  logic [31:0] z_exp [16];        // Expected Z, word r*4+n
  logic        busy_m;            // Run started, done not yet seen
  logic        started;
  logic        first_poll;        // Next STATUS read is the first after a start
  int          err_cnt = 0;
  int          chk_cnt = 0;

  // Z = X*W + bias, wraps at 32 bits like int arithmetic
  function automatic logic [31:0] calc_z(input int r, input int n);
    int                acc;
    logic signed [7:0] xv, wv;
    acc = b_sh[r];
    for (int k = 0; k < K_DIM; k++) begin
      xv  = x_sh[r*2 + k/4][8*(k%4) +: 8];
      wv  = w_sh[k][8*n +: 8];
      acc = acc + xv * wv;        // Signed product at 32 bits
    end
    return acc;
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old_w, new_w, input logic [3:0] sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Operand writes during a run are dropped, as in the DUT
  task automatic snoop_write(input logic [WB_AW-1:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
    int idx;
    if (adr >= ADDR_X_BASE && adr < ADDR_X_BASE + 32) begin
      idx = (adr - ADDR_X_BASE) >> 2;
      if (!busy_m) x_sh[idx] = merge(x_sh[idx], dat, sel);
    end else if (adr >= ADDR_W_BASE && adr < ADDR_W_BASE + 32) begin
      idx = (adr - ADDR_W_BASE) >> 2;
      if (!busy_m) w_sh[idx] = merge(w_sh[idx], dat, sel);
    end else if (adr >= ADDR_B_BASE && adr < ADDR_B_BASE + 16) begin
      idx = (adr - ADDR_B_BASE) >> 2;
      if (!busy_m) b_sh[idx] = merge(b_sh[idx], dat, sel);
    end else if (adr[9:2] == ADDR_CTRL[9:2] && sel[0] && dat[0] && !busy_m) begin
      for (int i = 0; i < 16; i++) z_exp[i] = calc_z(i / 4, i % 4);  // Snapshot at start
      busy_m     = 1'b1;
      started    = 1'b1;
      first_poll = 1'b1;
    end
  endtask

  task automatic snoop_read(input logic [WB_AW-1:0] adr, input logic [31:0] dat);
    int idx;
    if (adr[9:2] == ADDR_CTRL[9:2]) begin
      compare("CTRL", 32'h0, dat);
    end else if (adr[9:2] == ADDR_STATUS[9:2]) begin
      if (!started) begin
        compare("STATUS", 32'h0, dat);
      end else if (!busy_m) begin
        compare("STATUS", 32'h2, dat);  // Done sticks until next start
      end else if (first_poll) begin
        compare("STATUS", 32'h1, dat);  // Busy from the access after the start
        first_poll = 1'b0;
        if (dat == 32'h2) busy_m = 1'b0;
      end else begin
        chk_cnt++;
        if (dat == 32'h2) begin
          busy_m = 1'b0;
        end else if (dat != 32'h1) begin
          err_cnt++;
          $display("[ERROR] %0t STATUS expected 00000001 or 00000002 got %h", $time, dat);
        end
      end
    end else if (adr >= ADDR_X_BASE && adr < ADDR_X_BASE + 32) begin
      idx = (adr - ADDR_X_BASE) >> 2;
      compare($sformatf("X word %0d", idx), x_sh[idx], dat);
    end else if (adr >= ADDR_W_BASE && adr < ADDR_W_BASE + 32) begin
      idx = (adr - ADDR_W_BASE) >> 2;
      compare($sformatf("W word %0d", idx), w_sh[idx], dat);
    end else if (adr >= ADDR_B_BASE && adr < ADDR_B_BASE + 16) begin
      idx = (adr - ADDR_B_BASE) >> 2;
      compare($sformatf("BIAS[%0d]", idx), b_sh[idx], dat);
    end else if (adr >= ADDR_Z_BASE && adr < ADDR_Z_BASE + 64) begin
      idx = (adr - ADDR_Z_BASE) >> 2;
      compare($sformatf("Z[%0d][%0d]", idx / 4, idx % 4), z_exp[idx], dat);
    end else begin
      compare($sformatf("unmapped %h", adr), 32'h0, dat);
    end
  endtask

  // Request is still held in the ack cycle
  always @(posedge clk_i) begin : snoop
    if (!arst_n_i) begin
      for (int i = 0; i < 8; i++) x_sh[i] = '0;
      for (int i = 0; i < 8; i++) w_sh[i] = '0;
      for (int i = 0; i < 4; i++) b_sh[i] = '0;
      for (int i = 0; i < 16; i++) z_exp[i] = '0;
      busy_m     = 1'b0;
      started    = 1'b0;
      first_poll = 1'b0;
    end else if (wb_rsp_i.ack && wb_req_i.we) begin
      snoop_write(wb_req_i.adr, wb_req_i.dat, wb_req_i.sel);
    end else if (wb_rsp_i.ack) begin
      snoop_read(wb_req_i.adr, wb_rsp_i.dat);
    end
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

endmodule

// ==== testbench/mac_tb.sv ====
/*
 * Testbench top for the matrix-multiply engine. Drives Wishbone accesses,
 * runs six tests and prints the summary; mac_checker does the comparing.
 */
module mac_tb
  import mac_array_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF        = 4;       // 8 ns period
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 2000;

  logic    clk = 1'b0;
  logic    arst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  int      err_cnt, chk_cnt;
  int      test_num = 1;
  int      err_base = 0;

  mac_top u_dut (.clk_i(clk), .arst_n_i(arst_n), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp));

  mac_checker u_checker (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .wb_req_i  (wb_req),
    .wb_rsp_i  (wb_rsp),
    .err_cnt_o (err_cnt),
    .chk_cnt_o (chk_cnt)
  );

  always #CLK_HALF clk = ~clk;

  // Request held until ack, then dropped
  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [31:0] dat);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat, sel: 4'hF};
    @(posedge clk);
    while (!wb_rsp.ack) @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [31:0] dat);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0, sel: 4'hF};
    @(posedge clk);
    while (!wb_rsp.ack) @(posedge clk);
    dat = wb_rsp.dat;
    wb_req <= '0;
  endtask

  task automatic write_random_operands();
    for (int i = 0; i < 8; i++) wb_write(ADDR_X_BASE + WB_AW'(4*i), $urandom());
    for (int i = 0; i < 8; i++) wb_write(ADDR_W_BASE + WB_AW'(4*i), $urandom());
    for (int i = 0; i < 4; i++) wb_write(ADDR_B_BASE + WB_AW'(4*i), $urandom());
  endtask

  task automatic read_operands();
    logic [31:0] d;
    for (int i = 0; i < 8; i++) wb_read(ADDR_X_BASE + WB_AW'(4*i), d);
    for (int i = 0; i < 8; i++) wb_read(ADDR_W_BASE + WB_AW'(4*i), d);
    for (int i = 0; i < 4; i++) wb_read(ADDR_B_BASE + WB_AW'(4*i), d);
  endtask

  task automatic read_all_z();
    logic [31:0] d;
    for (int i = 0; i < 16; i++) wb_read(ADDR_Z_BASE + WB_AW'(4*i), d);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[1]) wb_read(ADDR_STATUS, st);  // Watchdog bounds this poll
  endtask

  task automatic end_test(input string name);
    @(posedge clk);                           // Let the checker see the last ack
    $display("test %0d %s: %0d errors", test_num, name, err_cnt - err_base);
    test_num++;
    err_base = err_cnt;
  endtask

  initial begin : watchdog
    #(NUM_TESTS * CYCLES_PER_TEST * 2 * CLK_HALF);
    $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    logic [31:0] d;
    wb_req = '0;
    arst_n = 1'b0;
    void'($urandom(66));
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;

    wb_read(ADDR_STATUS, d);                  // Reset values
    wb_read(ADDR_CTRL, d);
    wb_read(10'h200, d);
    read_all_z();
    end_test("reset values");

    write_random_operands();
    read_operands();
    end_test("operand readback");

    write_random_operands();
    wb_write(ADDR_CTRL, 32'h1);
    wait_done();
    read_all_z();
    end_test("random multiply");

    for (int i = 0; i < 8; i++) wb_write(ADDR_X_BASE + WB_AW'(4*i), 32'h8080_8080);
    for (int i = 0; i < 8; i++) wb_write(ADDR_W_BASE + WB_AW'(4*i), 32'h8080_8080);
    for (int i = 0; i < 4; i++) wb_write(ADDR_B_BASE + WB_AW'(4*i), 32'h7FFF_FFFF);
    wb_write(ADDR_CTRL, 32'h1);
    wait_done();
    read_all_z();
    end_test("extreme operands");

    for (int i = 0; i < 4; i++) wb_write(ADDR_B_BASE + WB_AW'(4*i), $urandom());
    wb_write(ADDR_CTRL, 32'h1);               // Same X and W, new bias
    wait_done();
    read_all_z();
    end_test("bias only restart");

    write_random_operands();
    wb_write(ADDR_CTRL, 32'h1);
    for (int i = 0; i < 4; i++) wb_write(ADDR_X_BASE + WB_AW'(4*i), $urandom());
    wb_write(ADDR_CTRL, 32'h1);               // Start while busy is ignored
    wait_done();
    read_all_z();
    read_operands();
    end_test("X writes while busy");

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
